// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module alu
	import core_pkg::*;
(
	input  opcode_t i_opcode,
	input  word_t   i_pc,
	input  word_t   i_op_a,
	input  word_t   i_op_b,
	input  word_t   i_imm,
	input  wire     i_use_imm,
	output word_t   o_result,
	output logic    o_branch_taken,
	output status_t o_status
);

	word_t opnd_b;
	word_t add_sum;
	word_t sub_diff;
	word_t br_target;
	logic  add_ovf, sub_ovf, br_ovf;
	logic  addr_oor, tgt_oor;
	logic  br_cond;

	// ------------------------------------------------------------------------
	// Shared adders and flags
	// ------------------------------------------------------------------------
	assign opnd_b  = i_use_imm ? i_imm : i_op_b;
	assign add_sum = i_op_a + opnd_b;   // ADD, ADDI and load/store address
	assign add_ovf = (i_op_a[`CORE_DATA_W-1] == opnd_b[`CORE_DATA_W-1]) &&
		(add_sum[`CORE_DATA_W-1] != i_op_a[`CORE_DATA_W-1]);

	assign sub_diff = i_op_a - i_op_b;
	assign sub_ovf  = (i_op_a[`CORE_DATA_W-1] != i_op_b[`CORE_DATA_W-1]) &&
		(sub_diff[`CORE_DATA_W-1] != i_op_a[`CORE_DATA_W-1]);

	// Branch offset is in bytes
	assign br_target = i_pc + i_imm;
	assign br_ovf    = (i_pc[`CORE_DATA_W-1] == i_imm[`CORE_DATA_W-1]) &&
		(br_target[`CORE_DATA_W-1] != i_pc[`CORE_DATA_W-1]);

	// Word index range
	assign addr_oor = (add_sum[`CORE_DATA_W-1:2] >= `CORE_DMEM_WORDS);
	assign tgt_oor  = (br_target[`CORE_DATA_W-1:2] >= `CORE_IMEM_WORDS);

	assign br_cond = (i_opcode == OP_BEQ) ? (i_op_a == i_op_b) : (i_op_a != i_op_b);

	// ------------------------------------------------------------------------
	// Result and status
	// ------------------------------------------------------------------------
	always_comb
	begin
		o_result       = '0;
		o_branch_taken = 1'b0;
		o_status       = ST_I_TYPE;
		case (i_opcode)
			OP_ADD:
			begin
				o_result = add_sum;
				o_status = add_ovf ? ST_OVERFLOW : ST_R_TYPE;
			end
			OP_SUB:
			begin
				o_result = sub_diff;
				o_status = sub_ovf ? ST_OVERFLOW : ST_R_TYPE;
			end
			OP_AND:
			begin
				o_result = i_op_a & i_op_b;
				o_status = ST_R_TYPE;
			end
			OP_OR:
			begin
				o_result = i_op_a | i_op_b;
				o_status = ST_R_TYPE;
			end
			OP_XOR:
			begin
				o_result = i_op_a ^ i_op_b;
				o_status = ST_R_TYPE;
			end
			OP_SLT:
			begin
				o_result = {{(`CORE_DATA_W-1){1'b0}}, ($signed(i_op_a) < $signed(i_op_b))};
				o_status = ST_R_TYPE;
			end
			OP_ADDI:
			begin
				o_result = add_sum;
				o_status = add_ovf ? ST_OVERFLOW : ST_I_TYPE;
			end
			OP_LW, OP_SW:
			begin
				o_result = add_sum;
				o_status = (add_ovf || addr_oor) ? ST_OVERFLOW : ST_I_TYPE;
			end
			OP_BEQ, OP_BNE:
			begin
				o_result = br_target;
				// Bad target only matters when taken
				if (br_cond && (br_ovf || tgt_oor))
					o_status = ST_OVERFLOW;
				else
					o_branch_taken = br_cond;
			end
			default: ;
		endcase
	end

	// Taken branch must have a valid target
	always_comb
	begin
		a_taken_not_ovf: assert #0 (!(o_branch_taken && (o_status == ST_OVERFLOW)))
			else $error("Branch taken with OVERFLOW status");
	end

endmodule

`default_nettype wire

// File: hw/core_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_fsm
	import core_pkg::*;
(
	input  wire     clk,
	input  wire     i_rst_n,
	input  wire     i_inst_nonzero,
	input  wire     i_is_eof,
	input  wire     i_is_branch,
	input  wire     i_mem_to_reg,
	input  wire     i_mem_write,
	input  wire     i_reg_write,
	input  word_t   i_alu_result,
	input  wire     i_branch_taken,
	input  status_t i_alu_status,
	input  word_t   i_d_rdata,
	output word_t   o_pc,
	output logic    o_rf_we,
	output word_t   o_rf_wdata,
	output logic    o_d_we,
	output status_t o_status,
	output logic    o_status_valid
);

	fsm_state_t state, state_nxt;
	word_t      pc, pc_nxt;
	status_t    status_r, status_nxt;
	logic       status_v_r, status_v_nxt;
	logic       d_we_r, d_we_nxt;
	logic       rf_we_r, rf_we_nxt;

	assign o_pc           = pc;
	assign o_rf_we        = rf_we_r;
	assign o_d_we         = d_we_r;
	assign o_status       = status_r;
	assign o_status_valid = status_v_r;

	// Load data or ALU result back to the register file
	assign o_rf_wdata = i_mem_to_reg ? i_d_rdata : i_alu_result;

	// ------------------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------------------
	always_comb
	begin
		state_nxt    = state;
		pc_nxt       = pc;
		status_nxt   = status_r;
		status_v_nxt = status_v_r;
		d_we_nxt     = d_we_r;
		rf_we_nxt    = rf_we_r;
		case (state)
			S_IDLE:
			begin
				if (i_inst_nonzero)
				begin
					if (i_is_eof)
					begin
						status_nxt   = ST_EOF;
						status_v_nxt = 1'b1;
						state_nxt    = S_HALT_EOF;
					end
					else
						state_nxt = S_FETCH;
				end
			end
			S_FETCH:  state_nxt = S_DECODE;
			S_DECODE: state_nxt = S_EXEC;
			S_EXEC:
			begin
				if (i_is_eof)
				begin
					status_nxt   = ST_EOF;
					status_v_nxt = 1'b1;
					state_nxt    = S_HALT_EOF;
				end
				else
					state_nxt = S_WB;
			end
			S_WB:
			begin
				status_nxt   = i_alu_status;
				status_v_nxt = 1'b1;
				if (i_alu_status == ST_OVERFLOW)
					state_nxt = S_HALT_OVF;     // Nothing gets written
				else
				begin
					d_we_nxt  = i_mem_write;
					rf_we_nxt = i_reg_write;
					state_nxt = S_NEXT;
				end
			end
			S_NEXT:
			begin
				status_v_nxt = 1'b0;
				d_we_nxt     = 1'b0;
				rf_we_nxt    = 1'b0;
				if (i_is_branch && i_branch_taken)
					pc_nxt = i_alu_result;
				else
					pc_nxt = pc + `CORE_PC_STEP;
				state_nxt = S_FETCH;
			end
			S_HALT_OVF, S_HALT_EOF: ;       // Held until reset
			default:  state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state      <= S_IDLE;
			pc         <= `CORE_RESET_PC;
			status_r   <= ST_R_TYPE;
			status_v_r <= 1'b0;
			d_we_r     <= 1'b0;
			rf_we_r    <= 1'b0;
		end
		else
		begin
			state      <= state_nxt;
			pc         <= pc_nxt;
			status_r   <= status_nxt;
			status_v_r <= status_v_nxt;
			d_we_r     <= d_we_nxt;
			rf_we_r    <= rf_we_nxt;
		end
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	a_we_with_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_d_we |-> o_status_valid)
		else $error("Data write without status valid");

	// An overflow never reaches the write cycle
	a_no_ovf_in_next: assert property (@(posedge clk) disable iff (!i_rst_n)
		(state == S_NEXT) |-> (o_status != ST_OVERFLOW))
		else $error("OVERFLOW status in NEXT");

endmodule

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

`include "core_macros.svh"

package core_pkg;

	typedef logic [`CORE_DATA_W-1:0]    word_t;     // Data, PC or address
	typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;

	typedef enum logic [5:0]
	{
		OP_ADD  = `CORE_OP_ADD,
		OP_SUB  = `CORE_OP_SUB,
		OP_ADDI = `CORE_OP_ADDI,
		OP_LW   = `CORE_OP_LW,
		OP_SW   = `CORE_OP_SW,
		OP_AND  = `CORE_OP_AND,
		OP_OR   = `CORE_OP_OR,
		OP_XOR  = `CORE_OP_XOR,
		OP_BEQ  = `CORE_OP_BEQ,
		OP_BNE  = `CORE_OP_BNE,
		OP_SLT  = `CORE_OP_SLT,
		OP_EOF  = `CORE_OP_EOF
	} opcode_t;

	typedef enum logic [1:0]
	{
		ST_R_TYPE   = 2'd0,
		ST_I_TYPE   = 2'd1,
		ST_OVERFLOW = 2'd2,
		ST_EOF      = 2'd3
	} status_t;

	// Sequencer states
	typedef enum logic [2:0]
	{
		S_IDLE,
		S_FETCH,
		S_DECODE,
		S_EXEC,
		S_WB,
		S_NEXT,
		S_HALT_OVF,
		S_HALT_EOF
	} fsm_state_t;

endpackage

`default_nettype wire

// File: hw/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top
	import core_pkg::*;
(
	input  wire     clk,
	input  wire     i_rst_n,
	output word_t   o_i_addr,
	input  word_t   i_i_inst,
	output logic    o_d_we,
	output word_t   o_d_addr,
	output word_t   o_d_wdata,
	input  word_t   i_d_rdata,
	output status_t o_status,
	output logic    o_status_valid
);

	// ------------------------------------------------------------------------
	// Interconnect
	// ------------------------------------------------------------------------
	opcode_t  opcode;
	reg_idx_t raddr_a, raddr_b, waddr;
	word_t    imm;
	word_t    rdata_a;
	word_t    rf_wdata;
	status_t  alu_status;
	logic     use_imm, mem_to_reg, mem_write, reg_write;
	logic     is_branch, is_eof, inst_nonzero;
	logic     branch_taken;
	logic     rf_we;

	inst_decode u_decode (
		.i_inst         (i_i_inst),
		.o_opcode       (opcode),
		.o_raddr_a      (raddr_a),
		.o_raddr_b      (raddr_b),
		.o_waddr        (waddr),
		.o_imm          (imm),
		.o_use_imm      (use_imm),
		.o_mem_to_reg   (mem_to_reg),
		.o_mem_write    (mem_write),
		.o_reg_write    (reg_write),
		.o_is_branch    (is_branch),
		.o_is_eof       (is_eof),
		.o_inst_nonzero (inst_nonzero)
	);

	reg_file u_regs (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_we      (rf_we),
		.i_waddr   (waddr),
		.i_wdata   (rf_wdata),
		.i_raddr_a (raddr_a),
		.i_raddr_b (raddr_b),
		.o_rdata_a (rdata_a),
		.o_rdata_b (o_d_wdata)      // Store data is read port B
	);

	alu u_alu (
		.i_opcode       (opcode),
		.i_pc           (o_i_addr),
		.i_op_a         (rdata_a),
		.i_op_b         (o_d_wdata),
		.i_imm          (imm),
		.i_use_imm      (use_imm),
		.o_result       (o_d_addr),
		.o_branch_taken (branch_taken),
		.o_status       (alu_status)
	);

	core_fsm u_fsm (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_inst_nonzero (inst_nonzero),
		.i_is_eof       (is_eof),
		.i_is_branch    (is_branch),
		.i_mem_to_reg   (mem_to_reg),
		.i_mem_write    (mem_write),
		.i_reg_write    (reg_write),
		.i_alu_result   (o_d_addr),
		.i_branch_taken (branch_taken),
		.i_alu_status   (alu_status),
		.i_d_rdata      (i_d_rdata),
		.o_pc           (o_i_addr),
		.o_rf_we        (rf_we),
		.o_rf_wdata     (rf_wdata),
		.o_d_we         (o_d_we),
		.o_status       (o_status),
		.o_status_valid (o_status_valid)
	);

endmodule

`default_nettype wire

// File: hw/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module inst_decode
	import core_pkg::*;
(
	input  word_t    i_inst,
	output opcode_t  o_opcode,
	output reg_idx_t o_raddr_a,
	output reg_idx_t o_raddr_b,
	output reg_idx_t o_waddr,
	output word_t    o_imm,
	output logic     o_use_imm,
	output logic     o_mem_to_reg,
	output logic     o_mem_write,
	output logic     o_reg_write,
	output logic     o_is_branch,
	output logic     o_is_eof,
	output logic     o_inst_nonzero
);

	// Fields
	assign o_opcode       = opcode_t'(i_inst[31:26]);
	assign o_raddr_a      = i_inst[25:21];
	assign o_raddr_b      = i_inst[20:16];
	assign o_imm          = {{(`CORE_DATA_W-16){i_inst[15]}}, i_inst[15:0]};
	assign o_inst_nonzero = |i_inst;

	// ------------------------------------------------------------------------
	// Control per opcode
	// ------------------------------------------------------------------------
	always_comb
	begin
		o_waddr      = '0;
		o_use_imm    = 1'b0;
		o_mem_to_reg = 1'b0;
		o_mem_write  = 1'b0;
		o_reg_write  = 1'b0;
		o_is_branch  = 1'b0;
		o_is_eof     = 1'b0;
		case (o_opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT:
			begin
				o_waddr     = i_inst[15:11];    // Field D
				o_reg_write = 1'b1;
			end
			OP_ADDI, OP_LW:
			begin
				o_waddr      = i_inst[20:16];   // Field B
				o_use_imm    = 1'b1;
				o_reg_write  = 1'b1;
				o_mem_to_reg = (o_opcode == OP_LW);
			end
			OP_SW:
			begin
				o_use_imm   = 1'b1;
				o_mem_write = 1'b1;
			end
			OP_BEQ, OP_BNE: o_is_branch = 1'b1;
			OP_EOF:         o_is_eof    = 1'b1;
			default: ;      // Unknown opcode, no write
		endcase
	end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module reg_file
	import core_pkg::*;
(
	input  wire      clk,
	input  wire      i_rst_n,
	input  wire      i_we,
	input  reg_idx_t i_waddr,
	input  word_t    i_wdata,
	input  reg_idx_t i_raddr_a,
	input  reg_idx_t i_raddr_b,
	output word_t    o_rdata_a,
	output word_t    o_rdata_b
);

	word_t regs [`CORE_REG_CNT];

	// Combinational reads
	assign o_rdata_a = regs[i_raddr_a];
	assign o_rdata_b = regs[i_raddr_b];

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			for (int i = 0; i < `CORE_REG_CNT; i++)
				regs[i] <= '0;
		end
		else if (i_we)
			regs[i_waddr] <= i_wdata;       // r0 is writable too
	end

	a_waddr_known: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_we |-> !$isunknown(i_waddr))
		else $error("Register write with unknown address");

endmodule

`default_nettype wire

// File: include/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath sizes
`define CORE_DATA_W      32
`define CORE_REG_CNT     32
`define CORE_REG_IDX_W   5

// Memory limits in words
`define CORE_DMEM_WORDS  64
`define CORE_IMEM_WORDS  1024

`define CORE_PC_STEP     4
`define CORE_RESET_PC    32'd0

// ----------------------------------------------------------------------------
// Opcodes, bits 31..26 of the instruction
// ----------------------------------------------------------------------------
`define CORE_OP_ADD      6'd0
`define CORE_OP_SUB      6'd1
`define CORE_OP_ADDI     6'd4
`define CORE_OP_LW       6'd5
`define CORE_OP_SW       6'd6
`define CORE_OP_AND      6'd7
`define CORE_OP_OR       6'd8
`define CORE_OP_XOR      6'd9
`define CORE_OP_BEQ      6'd10
`define CORE_OP_BNE      6'd11
`define CORE_OP_SLT      6'd12
`define CORE_OP_EOF      6'd19

`endif

// File: mcore.f
+incdir+include
hw/core_pkg.sv
hw/reg_file.sv
hw/inst_decode.sv
hw/alu.sv
hw/core_fsm.sv
hw/core_top.sv
verification/tb_core.sv

// File: verification/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module tb_core
	import core_pkg::*;
();

	localparam int          CLK_PERIOD   = 8;
	localparam int          HALT_TIMEOUT = 400;     // Cycles
	localparam logic [31:0] SEED         = 32'hbdf5ce53;

	logic    clk;
	logic    i_rst_n;
	word_t   inst_addr, inst_word;
	word_t   data_addr, data_wdata, data_rdata;
	logic    data_we;
	status_t status;
	logic    status_valid;
	logic    halted;
	integer  seed;

	word_t imem [`CORE_IMEM_WORDS];
	word_t dmem [`CORE_DMEM_WORDS];

	// Memories answer combinationally
	assign inst_word  = imem[inst_addr[11:2]];
	assign data_rdata = dmem[data_addr[7:2]];
	assign halted     = status_valid && (status == ST_EOF || status == ST_OVERFLOW);

	core_top i_dut (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.o_i_addr       (inst_addr),
		.i_i_inst       (inst_word),
		.o_d_we         (data_we),
		.o_d_addr       (data_addr),
		.o_d_wdata      (data_wdata),
		.i_d_rdata      (data_rdata),
		.o_status       (status),
		.o_status_valid (status_valid)
	);

	initial
		clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------------------
	// Data memory writes and strobe monitor
	// ------------------------------------------------------------------------
	int      cycle_cnt = 0;
	int      we_cnt;
	logic    we_q, we_back_to_back, valid_q;
	status_t pulse_status [$];
	int      pulse_cycle [$];

	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (!i_rst_n)
		begin
			we_cnt          = 0;
			we_q            = 1'b0;
			we_back_to_back = 1'b0;
			valid_q         = 1'b0;
			pulse_status.delete();
			pulse_cycle.delete();
		end
		else
		begin
			if (data_we)
			begin
				dmem[data_addr[7:2]] <= data_wdata;
				we_cnt = we_cnt + 1;
				if (we_q)
					we_back_to_back = 1'b1;
			end
			if (status_valid && !valid_q)       // Rising edge of valid
			begin
				pulse_status.push_back(status);
				pulse_cycle.push_back(cycle_cnt);
			end
			we_q    = data_we;
			valid_q = status_valid;
		end
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	function automatic word_t encode_rtype(input logic [5:0] op, input int a, input int b,
		input int d);
		return {op, 5'(a), 5'(b), 5'(d), 11'd0};
	endfunction

	function automatic word_t encode_itype(input logic [5:0] op, input int a, input int b,
		input int imm);
		return {op, 5'(a), 5'(b), 16'(imm)};
	endfunction

	function automatic word_t dmem_fill_word(input int idx);
		return 32'hd00d_0000 | word_t'(idx);
	endfunction

	// Register-register results
	function automatic word_t expected_rr(input logic [5:0] op, input word_t a, input word_t b);
		case (op)
			`CORE_OP_ADD: return a + b;
			`CORE_OP_SUB: return a - b;
			`CORE_OP_AND: return a & b;
			`CORE_OP_OR:  return a | b;
			`CORE_OP_XOR: return a ^ b;
			default:      return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
	endfunction

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		assert (got === exp)
		else
			fail_run($sformatf("error: %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_true(input logic cond, input string reason);
		assert (cond === 1'b1)
		else
			fail_run(reason);
	endtask

	task automatic clear_memories();
		for (int i = 0; i < `CORE_IMEM_WORDS; i++)
			imem[i] = {`CORE_OP_EOF, 26'(i)};   // Runaway fetch stops at EOF
		for (int i = 0; i < `CORE_DMEM_WORDS; i++)
			dmem[i] = dmem_fill_word(i);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1 i_rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1 i_rst_n = 1'b1;
	endtask

	task automatic wait_for_halt();
		int n;
		n = 0;
		while (!halted && n < HALT_TIMEOUT)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		check_true(halted, "timeout: the core never reached a halt state");
		@(posedge clk);     // Let the monitor see the last edge
		#1;
	endtask

	task automatic check_held(input status_t st, input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			check_true(status_valid, "status valid dropped during a halt");
			check_word(word_t'(status), word_t'(st), "held status");
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_pulse_count(input int exp);
		check_word(word_t'(pulse_status.size()), word_t'(exp), "status pulse count");
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic test_alu_ops();
		logic [5:0]  rr_ops [6];
		word_t       x, y;
		logic [15:0] imm16;
		status_t     exp_st [$];
		int          pc;
		rr_ops = '{`CORE_OP_ADD, `CORE_OP_SUB, `CORE_OP_AND, `CORE_OP_OR, `CORE_OP_XOR,
			`CORE_OP_SLT};
		x     = $signed($random(seed)) >>> 2;   // Small enough to never overflow
		y     = $signed($random(seed)) >>> 2;
		imm16 = $random(seed);
		clear_memories();
		dmem[0] = x;
		dmem[1] = y;
		imem[0] = encode_itype(`CORE_OP_LW, 0, 1, 0);
		imem[1] = encode_itype(`CORE_OP_LW, 0, 2, 4);
		exp_st  = '{ST_I_TYPE, ST_I_TYPE};
		pc = 2;
		for (int k = 0; k < 6; k++)
		begin
			imem[pc]     = encode_rtype(rr_ops[k], 1, 2, 3 + k);
			imem[pc + 1] = encode_itype(`CORE_OP_SW, 0, 3 + k, 8 + 4 * k);
			exp_st.push_back(ST_R_TYPE);
			exp_st.push_back(ST_I_TYPE);
			pc += 2;
		end
		imem[pc]     = encode_itype(`CORE_OP_ADDI, 1, 9, imm16);
		imem[pc + 1] = encode_itype(`CORE_OP_SW, 0, 9, 32);
		imem[pc + 2] = {`CORE_OP_EOF, 26'd0};
		exp_st.push_back(ST_I_TYPE);
		exp_st.push_back(ST_I_TYPE);
		exp_st.push_back(ST_EOF);
		apply_reset();
		wait_for_halt();
		check_word(word_t'(status), word_t'(ST_EOF), "final status");
		for (int k = 0; k < 6; k++)
			check_word(dmem[2 + k], expected_rr(rr_ops[k], x, y), $sformatf("result %0d", k));
		check_word(dmem[8], x + {{16{imm16[15]}}, imm16}, "ADDI result");
		check_pulse_count(exp_st.size());
		for (int k = 0; k < exp_st.size(); k++)
			check_word(word_t'(pulse_status[k]), word_t'(exp_st[k]), $sformatf("status %0d", k));
	endtask

	task automatic test_strobe_timing();
		clear_memories();
		imem[0] = encode_itype(`CORE_OP_LW, 0, 1, 0);
		imem[1] = encode_itype(`CORE_OP_SW, 0, 1, 8);
		imem[2] = encode_itype(`CORE_OP_ADDI, 1, 2, 1);
		imem[3] = encode_itype(`CORE_OP_SW, 0, 2, 12);
		imem[4] = encode_itype(`CORE_OP_SW, 0, 1, 16);
		apply_reset();
		wait_for_halt();
		check_word(word_t'(we_cnt), 32'd3, "write strobe cycles");
		check_true(!we_back_to_back, "write strobe stayed high for two cycles");
		check_pulse_count(6);
		for (int k = 1; k < 5; k++)
			check_word(word_t'(pulse_cycle[k] - pulse_cycle[k - 1]), 32'd5, "pulse spacing");
		check_word(dmem[2], dmem_fill_word(0), "stored load");
		check_word(dmem[3], dmem_fill_word(0) + 1, "stored sum");
	endtask

	task automatic test_branches();
		word_t a;
		a = $random(seed);
		clear_memories();
		dmem[0] = a;
		dmem[1] = ~a;
		imem[0] = encode_itype(`CORE_OP_LW, 0, 1, 0);
		imem[1] = encode_itype(`CORE_OP_LW, 0, 2, 4);
		imem[2] = encode_itype(`CORE_OP_BEQ, 1, 1, 8);     // Taken
		imem[3] = encode_itype(`CORE_OP_SW, 0, 1, 40);
		imem[4] = encode_itype(`CORE_OP_BNE, 1, 2, 8);     // Taken
		imem[5] = encode_itype(`CORE_OP_SW, 0, 1, 44);
		imem[6] = encode_itype(`CORE_OP_BEQ, 1, 2, 8);
		imem[7] = encode_itype(`CORE_OP_SW, 0, 1, 48);
		imem[8] = encode_itype(`CORE_OP_BNE, 1, 1, 8);
		imem[9] = encode_itype(`CORE_OP_SW, 0, 2, 52);
		apply_reset();
		wait_for_halt();
		check_word(word_t'(status), word_t'(ST_EOF), "final status");
		check_word(inst_addr, 32'd40, "PC at EOF");
		check_word(dmem[10], dmem_fill_word(10), "word skipped by BEQ");
		check_word(dmem[11], dmem_fill_word(11), "word skipped by BNE");
		check_word(dmem[12], a, "word after BEQ not taken");
		check_word(dmem[13], ~a, "word after BNE not taken");
		check_pulse_count(9);
	endtask

	task automatic test_overflow();
		clear_memories();
		dmem[0] = 32'h7000_0000 | ($random(seed) & 32'hffff);
		dmem[1] = 32'h6000_0000;
		imem[0] = encode_itype(`CORE_OP_LW, 0, 1, 0);
		imem[1] = encode_itype(`CORE_OP_LW, 0, 2, 4);
		imem[2] = encode_rtype(`CORE_OP_ADD, 1, 2, 3);
		imem[3] = encode_itype(`CORE_OP_SW, 0, 3, 8);
		apply_reset();
		wait_for_halt();
		check_held(ST_OVERFLOW, 10);
		check_word(word_t'(we_cnt), 32'd0, "writes after overflow");
		check_word(dmem[2], dmem_fill_word(2), "destination word");
		check_pulse_count(3);
	endtask

	task automatic test_range_errors();
		clear_memories();
		imem[0] = encode_itype(`CORE_OP_LW, 0, 1, 4 * `CORE_DMEM_WORDS);
		imem[1] = encode_itype(`CORE_OP_SW, 0, 0, 0);
		apply_reset();
		wait_for_halt();
		check_held(ST_OVERFLOW, 4);
		check_pulse_count(1);
		check_word(word_t'(we_cnt), 32'd0, "writes after load range error");
		clear_memories();
		imem[0] = encode_itype(`CORE_OP_BEQ, 0, 0, 4 * `CORE_IMEM_WORDS);
		imem[1] = encode_itype(`CORE_OP_SW, 0, 0, 0);
		apply_reset();
		wait_for_halt();
		check_held(ST_OVERFLOW, 4);
		check_pulse_count(1);
		check_word(word_t'(we_cnt), 32'd0, "writes after range error");
	endtask

	task automatic test_eof();
		clear_memories();       // Word 0 is already EOF
		imem[1] = encode_itype(`CORE_OP_SW, 0, 0, 0);
		apply_reset();
		wait_for_halt();
		check_held(ST_EOF, 4);
		check_pulse_count(1);
		check_word(word_t'(we_cnt), 32'd0, "writes with EOF first");
		clear_memories();
		imem[0] = encode_itype(`CORE_OP_ADDI, 0, 1, 5);
		imem[1] = encode_itype(`CORE_OP_SW, 0, 1, 0);
		apply_reset();
		wait_for_halt();
		check_word(dmem[0], 32'd5, "stored immediate");
		check_held(ST_EOF, 20);
	endtask

	initial
	begin
		seed    = SEED;
		i_rst_n = 1'b0;
		clear_memories();
		test_alu_ops();
		test_strobe_timing();
		test_branches();
		test_overflow();
		test_range_errors();
		test_eof();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
